// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // one queued byte transfer
    typedef struct packed
    {
        eeprom_op_e  op;
        logic [10:0] addr;
        logic [7:0]  data;
    } eeprom_cmd_t;

    // result of a finished transfer
    typedef struct packed
    {
        logic [7:0] data;
        logic       nack;
    } eeprom_rsp_t;

    localparam logic [3:0] DEV_CODE = 4'b1010; // upper nibble of the control byte

    // APB register offsets
    localparam logic [7:0] REG_CMD    = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_RDATA  = 8'h08;

endpackage

// ==== rtl/apb_eeprom_regs.sv ====
module apb_eeprom_regs
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    push,
    output eeprom_pkg::eeprom_cmd_t push_cmd,
    input  logic                    full,
    input  logic                    not_empty,
    input  logic                    active,
    input  logic                    rsp_valid,
    input  logic                    rsp_read,
    input  eeprom_pkg::eeprom_rsp_t rsp
);
    import eeprom_pkg::*;

    logic       access;
    logic       cmd_wr;
    logic       rdata_rd;
    logic       nack_sticky;
    logic       rd_valid;
    logic [7:0] rdata;
    logic [3:0] status;

    assign access   = psel && penable;
    assign cmd_wr   = access && pwrite && (paddr == REG_CMD);
    assign rdata_rd = access && !pwrite && (paddr == REG_RDATA);

    assign pready  = 1'b1; // no wait states
    assign push    = cmd_wr && !full;
    assign pslverr = cmd_wr && full; // overflow, command dropped

    always_comb
    begin
        push_cmd.op   = eeprom_op_e'(pwdata[20]);
        push_cmd.addr = pwdata[18:8];
        push_cmd.data = pwdata[7:0];
    end

    assign status = {rd_valid, nack_sticky, full, not_empty || active};

    always_comb
    begin
        prdata = '0;
        if (psel && !pwrite)
        begin
            case (paddr)
                REG_STATUS: prdata = {28'b0, status};
                REG_RDATA:  prdata = {24'b0, rdata};
                default:    prdata = '0;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            nack_sticky <= 1'b0;
            rd_valid    <= 1'b0;
        end
        else
        begin
            if (rdata_rd)
                rd_valid <= 1'b0;
            if (rsp_valid)
            begin
                nack_sticky <= rsp.nack;
                if (rsp_read)
                    rd_valid <= !rsp.nack; // a refused read invalidates old data
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rsp_valid && rsp_read && !rsp.nack)
            rdata <= rsp.data;
    end

endmodule

// ==== rtl/cmd_fifo.sv ====
module cmd_fifo
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    push,
    input  eeprom_pkg::eeprom_cmd_t push_cmd,
    output logic                    full,
    input  logic                    pop,
    output logic                    not_empty,
    output eeprom_pkg::eeprom_cmd_t head_cmd
);
    import eeprom_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    eeprom_cmd_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full; // ignored when full
    assign do_pop    = pop && not_empty;
    assign head_cmd  = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_cmd;
    end

endmodule

// ==== rtl/i2c_eeprom_master.sv ====
module i2c_eeprom_master
#(
    parameter int CLK_DIV = 4
)
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    not_empty,
    input  eeprom_pkg::eeprom_cmd_t head_cmd,
    output logic                    pop,
    output logic                    active,
    output logic                    rsp_valid,
    output logic                    rsp_read,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_low,
    input  logic                    sda_in
);
    import eeprom_pkg::*;

    localparam int TW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_START,
        ST_SEND,
        ST_GET_ACK,
        ST_RESTART,
        ST_RECV,
        ST_SEND_NACK,
        ST_STOP
    } state_e;

    state_e      state;
    eeprom_cmd_t cmd;
    logic [TW-1:0] tick_cnt;
    logic        tick;
    logic [1:0]  phase;    // quarter of the current bit
    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt; // 0 ctrl, 1 addr, 2 data or read ctrl
    logic [7:0]  shreg;
    logic        nack_flag;
    logic        scl_c;
    logic        sda_low_c;
    logic [7:0]  ctrl_w;
    logic [7:0]  ctrl_r;

    assign tick   = (tick_cnt == TW'(CLK_DIV - 1));
    assign ctrl_w = {DEV_CODE, cmd.addr[10:8], 1'b0};
    assign ctrl_r = {DEV_CODE, cmd.addr[10:8], 1'b1};
    assign pop    = (state == ST_IDLE) && not_empty;
    assign active = (state != ST_IDLE) || rsp_valid;

    // scl high in quarters 1 and 2 of a normal bit
    always_comb
    begin
        scl_c     = phase[0] ^ phase[1];
        sda_low_c = 1'b0;
        case (state)
            ST_IDLE:    scl_c = 1'b1;
            ST_START:
            begin
                scl_c     = (phase != 2'd3);
                sda_low_c = phase[1]; // falls with scl high
            end
            ST_RESTART: sda_low_c = phase[1];
            ST_SEND:    sda_low_c = !shreg[7];
            ST_STOP:
            begin
                scl_c     = (phase != 2'd0);
                sda_low_c = !phase[1]; // rises with scl high
            end
            default:    sda_low_c = 1'b0; // ack, receive and master nack release sda
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            tick_cnt  <= '0;
            phase     <= 2'd0;
            bit_cnt   <= 3'd0;
            byte_cnt  <= 2'd0;
            nack_flag <= 1'b0;
            rsp_valid <= 1'b0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
        end
        else
        begin
            scl       <= scl_c;
            sda_low   <= sda_low_c;
            rsp_valid <= 1'b0;
            if (state == ST_IDLE)
            begin
                tick_cnt <= '0;
                phase    <= 2'd0;
                if (not_empty)
                begin
                    cmd       <= head_cmd;
                    nack_flag <= 1'b0;
                    state     <= ST_START;
                end
            end
            else if (!tick)
                tick_cnt <= tick_cnt + 1'b1;
            else
            begin
                tick_cnt <= '0;
                phase    <= phase + 2'd1;
                if (phase == 2'd1) // middle of scl high
                begin
                    if (state == ST_GET_ACK)
                        nack_flag <= sda_in;
                    else if (state == ST_RECV)
                        shreg <= {shreg[6:0], sda_in};
                end
                if (phase == 2'd3) // end of bit
                begin
                    case (state)
                        ST_START:
                        begin
                            shreg    <= ctrl_w;
                            byte_cnt <= 2'd0;
                            bit_cnt  <= 3'd0;
                            state    <= ST_SEND;
                        end
                        ST_RESTART:
                        begin
                            shreg    <= ctrl_r;
                            byte_cnt <= 2'd2;
                            bit_cnt  <= 3'd0;
                            state    <= ST_SEND;
                        end
                        ST_SEND:
                        begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= ST_GET_ACK;
                        end
                        ST_GET_ACK:
                        begin
                            if (nack_flag)
                                state <= ST_STOP; // slave refused, abort
                            else if (byte_cnt == 2'd0)
                            begin
                                shreg    <= cmd.addr[7:0];
                                byte_cnt <= 2'd1;
                                state    <= ST_SEND;
                            end
                            else if (byte_cnt == 2'd1 && cmd.op == OP_READ)
                                state <= ST_RESTART;
                            else if (byte_cnt == 2'd1)
                            begin
                                shreg    <= cmd.data;
                                byte_cnt <= 2'd2;
                                state    <= ST_SEND;
                            end
                            else if (cmd.op == OP_READ)
                                state <= ST_RECV;
                            else
                                state <= ST_STOP;
                        end
                        ST_RECV:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= ST_SEND_NACK;
                        end
                        ST_SEND_NACK: state <= ST_STOP;
                        ST_STOP:
                        begin
                            rsp_valid <= 1'b1;
                            rsp.data  <= shreg;
                            rsp.nack  <= nack_flag;
                            rsp_read  <= (cmd.op == OP_READ);
                            state     <= ST_IDLE;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
            end
        end
    end

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
module eeprom_ctrl_top
#(
    parameter int FIFO_DEPTH = 4,
    parameter int CLK_DIV    = 4
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_low,
    input  logic        sda_in
);
    import eeprom_pkg::*;

    eeprom_cmd_t push_cmd;
    eeprom_cmd_t head_cmd;
    eeprom_rsp_t rsp;
    logic        push;
    logic        full;
    logic        pop;
    logic        not_empty;
    logic        active;
    logic        rsp_valid;
    logic        rsp_read;

    apb_eeprom_regs u_regs
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_cmd  (push_cmd),
        .full      (full),
        .not_empty (not_empty),
        .active    (active),
        .rsp_valid (rsp_valid),
        .rsp_read  (rsp_read),
        .rsp       (rsp)
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (push),
        .push_cmd  (push_cmd),
        .full      (full),
        .pop       (pop),
        .not_empty (not_empty),
        .head_cmd  (head_cmd)
    );

    i2c_eeprom_master #(.CLK_DIV(CLK_DIV)) u_master
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .not_empty (not_empty),
        .head_cmd  (head_cmd),
        .pop       (pop),
        .active    (active),
        .rsp_valid (rsp_valid),
        .rsp_read  (rsp_read),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

// ==== testbench/eeprom_model.sv ====
module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic refuse,
    output logic pull
);
    import eeprom_pkg::*;

    logic [7:0]  mem [2048];
    logic [7:0]  shreg;
    logic [10:0] addr;
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx;  // bytes taken since the last start
    logic        selected;
    logic        sending;   // slave drives read data
    logic        ack_slot;
    logic        read_req;
    logic        prev_scl;
    logic        prev_sda;

    always @(posedge CLK)
    begin
        logic ack;
        ack = 1'b0;
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'(i) ^ 8'(i >> 3) ^ 8'ha5;
            pull     <= 1'b0;
            selected <= 1'b0;
            sending  <= 1'b0;
            ack_slot <= 1'b0;
            read_req <= 1'b0;
            prev_scl <= 1'b1;
            prev_sda <= 1'b1;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (scl && prev_scl && prev_sda && !sda) // start or repeated start
            begin
                selected <= 1'b1;
                sending  <= 1'b0;
                ack_slot <= 1'b0;
                pull     <= 1'b0;
                bit_cnt  <= 4'd0;
                byte_idx <= 2'd0;
            end
            else if (scl && prev_scl && !prev_sda && sda) // stop
            begin
                selected <= 1'b0;
                sending  <= 1'b0;
            end
            else if (selected && !prev_scl && scl)
            begin
                if (!ack_slot)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (!sending)
                        shreg <= {shreg[6:0], sda};
                end
            end
            else if (selected && prev_scl && !scl)
            begin
                if (ack_slot && sending)
                begin
                    selected <= 1'b0; // master nack seen, read done
                    sending  <= 1'b0;
                    ack_slot <= 1'b0;
                end
                else if (ack_slot)
                begin
                    ack_slot <= 1'b0;
                    bit_cnt  <= 4'd0;
                    pull     <= 1'b0;
                    if (read_req)
                    begin
                        sending <= 1'b1;
                        shreg   <= mem[addr];
                        pull    <= !mem[addr][7];
                    end
                end
                else if (bit_cnt == 4'd8 && sending)
                begin
                    pull     <= 1'b0; // let the master answer
                    ack_slot <= 1'b1;
                end
                else if (bit_cnt == 4'd8)
                begin
                    ack = !refuse;
                    case (byte_idx)
                        2'd0:
                        begin
                            ack = ack && (shreg[7:4] == DEV_CODE);
                            addr[10:8] <= shreg[3:1];
                            read_req   <= shreg[0];
                        end
                        2'd1: addr[7:0] <= shreg;
                        2'd2:
                        begin
                            if (ack)
                                mem[addr] <= shreg;
                        end
                        default: ack = 1'b0;
                    endcase
                    if (byte_idx != 2'd3)
                        byte_idx <= byte_idx + 2'd1;
                    pull     <= ack;
                    ack_slot <= ack;
                    selected <= ack; // unacked byte, ignore until next start
                end
                else if (sending)
                begin
                    shreg <= {shreg[6:0], 1'b0};
                    pull  <= !shreg[6];
                end
            end
        end
    end

endmodule

// ==== testbench/tb_eeprom_ctrl.sv ====
module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int CLK_DIV    = 4;
    localparam int N_CMDS     = 32; // upper bound on commands in the run
    localparam int BIT_TIME   = 4 * CLK_DIV * 10;

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_low;
    logic        sda;
    logic        model_pull;
    logic        refuse;

    logic [7:0]  sb [2048];
    logic [10:0] q_addr [FIFO_DEPTH+1];
    logic [10:0] a;
    logic [31:0] rd;
    logic        err;
    int          seed;
    int          errors = 0;
    int          checks = 0;
    int          mon_errors = 0;
    int          ready_errors = 0;
    int          exp_stops = 0;
    int          exp_restarts = 0;
    int          n_start = 0;
    int          n_stop = 0;
    int          n_restart = 0;
    logic        bus_busy;
    logic        prev_scl;
    logic        prev_sda;

    assign sda = !sda_low && !model_pull; // open-drain wired-AND

    eeprom_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .CLK_DIV(CLK_DIV)) dut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model u_model
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .scl    (scl),
        .sda    (sda),
        .refuse (refuse),
        .pull   (model_pull)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    assert property (@(posedge CLK) (psel && penable) |-> pready)
    else
    begin
        ready_errors++;
        $display("ERR %0t pready expected 1 actual %b", $time, pready);
    end

    // start and stop bookkeeping on the resolved bus
    always @(posedge CLK)
    begin
        if (RESET)
            bus_busy = 1'b0;
        else
        begin
            assert (!((scl != prev_scl) && (sda != prev_sda)))
            else
            begin
                mon_errors++;
                $display("ERR %0t sda expected %b actual %b", $time, prev_sda, sda);
            end
            if (scl && prev_scl && prev_sda && !sda)
            begin
                n_start++;
                if (bus_busy)
                    n_restart++;
                bus_busy = 1'b1;
            end
            else if (scl && prev_scl && !prev_sda && sda)
            begin
                n_stop++;
                assert (bus_busy)
                else
                begin
                    mon_errors++;
                    $display("stop condition seen on an idle bus at %0t", $time);
                end
                bus_busy = 1'b0;
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

    initial
    begin
        #(N_CMDS * 40 * BIT_TIME + 20000);
        $display("watchdog expired before the test sequence finished");
        $display("checks %0d errors %0d bus errors %0d pready errors %0d",
                 checks, errors, mon_errors, ready_errors);
        $display("Test failures found");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act == exp)
        else
        begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slv_err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        rdata   = prdata;
        slv_err = pslverr;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic slv_err;
        apb_access(1'b0, addr, 32'h0, rdata, slv_err);
    endtask

    function automatic logic [31:0] cmd_word(input logic op, input logic [10:0] addr,
                                             input logic [7:0] data);
        return {11'b0, op, 1'b0, addr, data}; // op bit 20, addr 18:8
    endfunction

    task automatic push_write(input logic [10:0] addr, input logic [7:0] data,
                              output logic slv_err);
        logic [31:0] rd_dummy;
        apb_access(1'b1, REG_CMD, cmd_word(OP_WRITE, addr, data), rd_dummy, slv_err);
        if (!slv_err)
        begin
            exp_stops++;
            if (!refuse)
                sb[addr] = data;
        end
    endtask

    task automatic push_read(input logic [10:0] addr, output logic slv_err);
        logic [31:0] rd_dummy;
        apb_access(1'b1, REG_CMD, cmd_word(OP_READ, addr, 8'h00), rd_dummy, slv_err);
        if (!slv_err)
        begin
            exp_stops++;
            if (!refuse)
                exp_restarts++;
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        apb_read(REG_STATUS, st);
        while (st[0])
            apb_read(REG_STATUS, st);
    endtask

    task automatic read_back(input logic [10:0] addr);
        logic [31:0] st;
        logic [31:0] data;
        logic        slv_err;
        push_read(addr, slv_err);
        check_value("pslverr", 32'd0, 32'(slv_err));
        wait_idle();
        apb_read(REG_STATUS, st);
        check_value("status", 32'h8, st); // rd_valid only
        apb_read(REG_RDATA, data);
        check_value("rdata", 32'(sb[addr]), data);
    endtask

    initial
    begin
        seed    = 32'h35d8;
        RESET   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        refuse  = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        check_value("scl", 32'd1, 32'(scl));
        check_value("sda_low", 32'd0, 32'(sda_low));
        apb_read(REG_STATUS, rd);
        check_value("status", 32'h0, rd);

        a = 11'($random(seed));
        push_write(a, 8'($random(seed)), err);
        check_value("pslverr", 32'd0, 32'(err));
        read_back(a);
        apb_read(REG_STATUS, rd);
        check_value("status", 32'h0, rd); // rd_valid cleared by the rdata read

        // upper address bits go out in the control byte
        push_write(11'h005, 8'($random(seed)), err);
        push_write(11'h305, 8'($random(seed)), err);
        read_back(11'h005);
        read_back(11'h305);

        // one in the engine, FIFO_DEPTH waiting
        for (int i = 0; i <= FIFO_DEPTH; i++)
        begin
            q_addr[i] = 11'h100 + 11'(i * 'h111);
            push_write(q_addr[i], 8'($random(seed)), err);
            check_value("pslverr", 32'd0, 32'(err));
        end
        push_write(11'h005, ~sb[11'h005], err);
        check_value("pslverr", 32'd1, 32'(err));
        apb_read(REG_STATUS, rd);
        check_value("status", 32'h3, rd);
        wait_idle();
        for (int i = 0; i <= FIFO_DEPTH; i++)
            read_back(q_addr[i]);
        read_back(11'h005);

        @(negedge CLK);
        refuse = 1'b1;
        push_read(11'h305, err);
        wait_idle();
        apb_read(REG_STATUS, rd);
        check_value("status", 32'h4, rd); // nack, no rd_valid
        push_write(11'h305, ~sb[11'h305], err);
        wait_idle();
        apb_read(REG_STATUS, rd);
        check_value("status", 32'h4, rd);
        @(negedge CLK);
        refuse = 1'b0;
        read_back(11'h305);

        check_value("n_start", 32'(n_stop + n_restart), 32'(n_start));
        check_value("n_stop", 32'(exp_stops), 32'(n_stop));
        check_value("n_restart", 32'(exp_restarts), 32'(n_restart));

        $display("checks %0d errors %0d bus errors %0d pready errors %0d",
                 checks, errors, mon_errors, ready_errors);
        if (errors == 0 && mon_errors == 0 && ready_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
rtl/eeprom_pkg.sv
rtl/apb_eeprom_regs.sv
rtl/cmd_fifo.sv
rtl/i2c_eeprom_master.sv
rtl/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/tb_eeprom_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_eeprom_ctrl -o sim_eeprom
out=$(./obj_dir/sim_eeprom)
echo "$out"
echo "$out" | grep -q 'All tests passed!'
